// ==== list.f ====
+incdir+hw
hw/core_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/pipeline_core.sv
verification/isa_model.sv
verification/core_tb.sv

// ==== Makefile ====
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= core_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/core_tb.sv ====
`include "core_defs.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TOTAL_RETIRES = 60 + 400 + 400 + 300 + 300 + 2000;
    // a taken redirect costs at most four cycles per retire
    localparam int CYCLE_LIMIT = 4 * TOTAL_RETIRES + 100;

    logic               clk;
    logic               rst;
    logic [`XLEN-1:0]   inst_addr;
    logic [`XLEN-1:0]   inst;
    core_pkg::mem_req_t mem_req;
    logic [`XLEN-1:0]   mem_rdata;
    core_pkg::retire_t  retire;

    logic [`XLEN-1:0] rom [256];
    logic [`XLEN-1:0] dmem [64];
    logic             load_mem;
    int               errors;
    int               tests_run;
    int               tests_ok;
    int               cycles;

    pipeline_core pipeline_core_inst (
        .clk       (clk),
        .rst       (rst),
        .inst_addr (inst_addr),
        .inst      (inst),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .retire    (retire)
    );

    // both memories answer combinationally and wrap on their size
    assign inst      = rom[inst_addr[9:2]];
    assign mem_rdata = dmem[mem_req.addr[7:2]];

    always @(posedge clk) begin
        if (load_mem) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= isa_model::dmem[i];
            end
        end else if (mem_req.we) begin
            dmem[mem_req.addr[7:2]] <= mem_req.wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] want);
        if (got !== want) begin
            $display("Fail %s: got %h, expected %h at %0t", name, got, want, $time);
            errors++;
        end
    endtask

    // rst spans eight rising edges, memories load on the last one
    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (7) @(posedge clk);
        @(negedge clk);
        foreach (rom[i]) begin
            rom[i] = isa_model::prog[i];
        end
        load_mem = 1'b1;
        @(posedge clk);
        @(negedge clk);
        compare("retire.valid", 32'(retire.valid), 32'd0);
        compare("mem_req.we", 32'(mem_req.we), 32'd0);
        compare("inst_addr", inst_addr, `RESET_PC);
        load_mem = 1'b0;
        rst      = 1'b0;
    endtask

    task automatic check_retire(input core_pkg::retire_t want);
        compare("retire.pc", retire.pc, want.pc);
        compare("retire.we", 32'(retire.we), 32'(want.we));
        compare("retire.rd", 32'(retire.rd), 32'(want.rd));
        if (want.we) begin
            compare("retire.data", retire.data, want.data);
        end
    endtask

    task automatic run_test(input string name, input int kinds, input int count);
        core_pkg::retire_t want;
        int                errs_before;
        errs_before = errors;
        isa_model::reset_state();
        isa_model::gen_program(kinds);
        apply_reset();
        for (int i = 0; i < count; i++) begin
            // outputs are registered, so the falling edge sees them settled
            @(negedge clk);
            while (!retire.valid) begin
                @(negedge clk);
            end
            isa_model::step(want);
            check_retire(want);
        end
        for (int i = 0; i < 64; i++) begin
            compare($sformatf("dmem[%0d]", i), dmem[i], isa_model::dmem[i]);
        end
        tests_run++;
        if (errors == errs_before) begin
            tests_ok++;
            $display("%-11s ok, %0d retires", name, count);
        end else begin
            $display("%-11s bad, %0d mismatches", name, errors - errs_before);
        end
    endtask

    initial begin
        rst       = 1'b1;
        load_mem  = 1'b0;
        errors    = 0;
        tests_run = 0;
        tests_ok  = 0;
        foreach (rom[i]) begin
            rom[i] = '0;
        end
        void'($urandom(92));
        run_test("reset", isa_model::K_ALU | isa_model::K_IMM, 60);
        run_test("alu_imm", isa_model::K_ALU | isa_model::K_IMM, 400);
        run_test("load_store", isa_model::K_IMM | isa_model::K_MEM, 400);
        run_test("branch", isa_model::K_IMM | isa_model::K_BR, 300);
        run_test("jump", isa_model::K_IMM | isa_model::K_JMP, 300);
        run_test("mixed", 31, 2000);
        $display("%0d tests run, %0d ok, %0d mismatches", tests_run, tests_ok, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verification/isa_model.sv ====
`include "core_defs.svh"

package isa_model;

    // instruction classes the program generator can mix
    localparam int K_ALU = 1;
    localparam int K_IMM = 2;
    localparam int K_MEM = 4;
    localparam int K_BR  = 8;
    localparam int K_JMP = 16;

    localparam logic [13:0][5:0] ALU_FN = {
        core_pkg::FN_SLL, core_pkg::FN_SRL, core_pkg::FN_SRA, core_pkg::FN_SLLV,
        core_pkg::FN_SRLV, core_pkg::FN_ADD, core_pkg::FN_ADDU, core_pkg::FN_SUB,
        core_pkg::FN_SUBU, core_pkg::FN_AND, core_pkg::FN_OR, core_pkg::FN_XOR,
        core_pkg::FN_NOR, core_pkg::FN_SLT
    };

    localparam logic [6:0][5:0] IMM_OP = {
        core_pkg::OP_ADDI, core_pkg::OP_ADDIU, core_pkg::OP_SLTI, core_pkg::OP_ANDI,
        core_pkg::OP_ORI, core_pkg::OP_XORI, core_pkg::OP_LUI
    };

    localparam logic [4:0][5:0] BR_OP = {
        core_pkg::OP_BEQ, core_pkg::OP_BNE, core_pkg::OP_BLEZ, core_pkg::OP_BGTZ,
        core_pkg::OP_REGIMM
    };

    // architectural state, the program is shared with the testbench ROM
    logic [`XLEN-1:0] prog [256];
    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic [`XLEN-1:0] dmem [64];
    logic [`XLEN-1:0] pc;

    function automatic void reset_state();
        pc = `RESET_PC;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        // every word depends on its full index
        foreach (dmem[i]) begin
            dmem[i] = 32'hc0de_0000 ^ (32'(i) * 32'h0001_0203);
        end
    endfunction

    function automatic logic [`XLEN-1:0] gen_inst(input int kind);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic [15:0] imm;
        logic [15:0] off;
        logic [5:0]  op;
        int          sel;
        rs  = 5'($urandom_range(31, 0));
        rt  = 5'($urandom_range(31, 0));
        // r31 stays reserved for JAL so JR always lands on an aligned address
        dst = 5'($urandom_range(30, 0));
        imm = 16'($urandom());
        off = 16'($urandom_range(24, 0)) - 16'd6;
        case (kind)
            K_ALU: begin
                sel = $urandom_range(13, 0);
                return {6'h00, rs, rt, dst, 5'($urandom_range(31, 0)), ALU_FN[sel]};
            end
            K_IMM: begin
                sel = $urandom_range(6, 0);
                return {IMM_OP[sel], rs, dst, imm};
            end
            K_MEM: begin
                if ($urandom_range(1, 0) == 0) begin
                    return {core_pkg::OP_LW, rs, dst, imm};
                end
                return {core_pkg::OP_SW, rs, rt, imm};
            end
            K_BR: begin
                sel = $urandom_range(4, 0);
                op  = BR_OP[sel];
                if (op == core_pkg::OP_BLEZ || op == core_pkg::OP_BGTZ) begin
                    rt = 5'd0;
                end else if (op == core_pkg::OP_REGIMM) begin
                    rt = 5'd1;
                end
                return {op, rs, rt, off};
            end
            default: begin
                sel = $urandom_range(2, 0);
                if (sel == 0) begin
                    return {core_pkg::OP_J, 26'($urandom_range(255, 0))};
                end
                if (sel == 1) begin
                    return {core_pkg::OP_JAL, 26'($urandom_range(255, 0))};
                end
                return {6'h00, 5'd31, 15'd0, core_pkg::FN_JR};
            end
        endcase
    endfunction

    // one random instruction in every third slot, two nops after each
    function automatic void gen_program(input int kinds);
        int kind;
        foreach (prog[i]) begin
            prog[i] = '0;
            if ((i % 3 == 0) && (i < 255)) begin
                do begin
                    kind = 1 << $urandom_range(4, 0);
                end while ((kind & kinds) == 0);
                prog[i] = gen_inst(kind);
            end
        end
    endfunction

    // executes the instruction at pc and returns what should retire
    function automatic void step(output core_pkg::retire_t want);
        logic [`XLEN-1:0] inst;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] simm;
        logic [`XLEN-1:0] zimm;
        logic [`XLEN-1:0] pc4;
        logic [`XLEN-1:0] next;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] val;
        logic [4:0]       sh;
        logic [4:0]       dest;
        inst = prog[pc[9:2]];
        a    = regs[inst[25:21]];
        b    = regs[inst[20:16]];
        sh   = inst[10:6];
        simm = {{16{inst[15]}}, inst[15:0]};
        zimm = {16'h0000, inst[15:0]};
        pc4  = pc + 32'd4;
        next = pc4;
        addr = a + simm;
        dest = '0;
        val  = '0;
        case (inst[31:26])
            core_pkg::OP_RTYPE: begin
                dest = inst[15:11];
                case (inst[5:0])
                    core_pkg::FN_SLL:  val = b << sh;
                    core_pkg::FN_SRL:  val = b >> sh;
                    core_pkg::FN_SRA:  val = $unsigned($signed(b) >>> sh);
                    core_pkg::FN_SLLV: val = b << a[4:0];
                    core_pkg::FN_SRLV: val = b >> a[4:0];
                    core_pkg::FN_ADD, core_pkg::FN_ADDU: val = a + b;
                    core_pkg::FN_SUB, core_pkg::FN_SUBU: val = a - b;
                    core_pkg::FN_AND:  val = a & b;
                    core_pkg::FN_OR:   val = a | b;
                    core_pkg::FN_XOR:  val = a ^ b;
                    core_pkg::FN_NOR:  val = ~(a | b);
                    core_pkg::FN_SLT:  val = {31'd0, $signed(a) < $signed(b)};
                    core_pkg::FN_JR: begin
                        dest = '0;
                        next = a;
                    end
                    default: dest = '0;
                endcase
            end
            core_pkg::OP_ADDI, core_pkg::OP_ADDIU: begin
                dest = inst[20:16];
                val  = a + simm;
            end
            core_pkg::OP_SLTI: begin
                dest = inst[20:16];
                val  = {31'd0, $signed(a) < $signed(simm)};
            end
            core_pkg::OP_ANDI: begin
                dest = inst[20:16];
                val  = a & zimm;
            end
            core_pkg::OP_ORI: begin
                dest = inst[20:16];
                val  = a | zimm;
            end
            core_pkg::OP_XORI: begin
                dest = inst[20:16];
                val  = a ^ zimm;
            end
            core_pkg::OP_LUI: begin
                dest = inst[20:16];
                val  = {inst[15:0], 16'h0000};
            end
            core_pkg::OP_LW: begin
                dest = inst[20:16];
                val  = dmem[addr[7:2]];
            end
            core_pkg::OP_SW: dmem[addr[7:2]] = b;
            core_pkg::OP_BEQ: next = (a == b) ? pc4 + (simm << 2) : pc4;
            core_pkg::OP_BNE: next = (a != b) ? pc4 + (simm << 2) : pc4;
            core_pkg::OP_BLEZ: next = ($signed(a) <= 0) ? pc4 + (simm << 2) : pc4;
            core_pkg::OP_BGTZ: next = ($signed(a) > 0) ? pc4 + (simm << 2) : pc4;
            core_pkg::OP_REGIMM: next = ($signed(a) >= 0) ? pc4 + (simm << 2) : pc4;
            core_pkg::OP_J: next = {pc4[31:28], inst[25:0], 2'b00};
            core_pkg::OP_JAL: begin
                next = {pc4[31:28], inst[25:0], 2'b00};
                dest = 5'(`LINK_REG);
                val  = pc4;
            end
            default: dest = '0;
        endcase
        if (dest != '0) begin
            regs[dest] = val;
        end
        want.valid = 1'b1;
        want.pc    = pc;
        want.we    = (dest != '0);
        want.rd    = dest;
        want.data  = val;
        pc = next;
    endfunction

endpackage

// ==== hw/pipeline_core.sv ====
`include "core_defs.svh"

module pipeline_core (
    input  logic               clk,
    input  logic               rst,
    output logic [`XLEN-1:0]   inst_addr,
    input  logic [`XLEN-1:0]   inst,
    output core_pkg::mem_req_t mem_req,
    input  logic [`XLEN-1:0]   mem_rdata,
    output core_pkg::retire_t  retire
);
    core_pkg::if_id_t  if_id;
    core_pkg::id_ex_t  id_ex;
    core_pkg::ex_mem_t ex_mem;
    logic              redirect;
    logic [`XLEN-1:0]  redirect_pc;
    logic [4:0]        rs_num;
    logic [4:0]        rt_num;
    logic [`XLEN-1:0]  rs_data;
    logic [`XLEN-1:0]  rt_data;

    fetch_stage u_fetch (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst        (inst),
        .inst_addr   (inst_addr),
        .if_id       (if_id)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst      (rst),
        .redirect (redirect),
        .if_id    (if_id),
        .rs_num   (rs_num),
        .rt_num   (rt_num),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .id_ex    (id_ex)
    );

    execute_stage u_execute (
        .clk      (clk),
        .rst      (rst),
        .redirect (redirect),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem)
    );

    memory_stage u_memory (
        .clk         (clk),
        .rst         (rst),
        .ex_mem      (ex_mem),
        .mem_req     (mem_req),
        .mem_rdata   (mem_rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .retire      (retire)
    );

    // the retire port doubles as the register file write port
    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .retire  (retire)
    );

endmodule

// ==== hw/memory_stage.sv ====
`include "core_defs.svh"

module memory_stage (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::ex_mem_t  ex_mem,
    output core_pkg::mem_req_t mem_req,
    input  logic [`XLEN-1:0]   mem_rdata,
    output logic               redirect,
    output logic [`XLEN-1:0]   redirect_pc,
    output core_pkg::retire_t  retire
);
    logic             taken;
    logic [`XLEN-1:0] wb_data;

    // flags come from rs - rt, or from rs - 0 for the compare-with-zero forms
    always_comb begin
        case (ex_mem.ctrl.branch)
            core_pkg::BR_EQ:  taken = ex_mem.zero;
            core_pkg::BR_NE:  taken = !ex_mem.zero;
            core_pkg::BR_LEZ: taken = ex_mem.zero || ex_mem.negative;
            core_pkg::BR_GTZ: taken = !ex_mem.zero && !ex_mem.negative;
            core_pkg::BR_GEZ: taken = !ex_mem.negative;
            default:          taken = 1'b0;
        endcase
    end

    assign redirect = ex_mem.valid && (taken || ex_mem.ctrl.jump || ex_mem.ctrl.jump_reg);
    assign redirect_pc = ex_mem.ctrl.jump_reg ? ex_mem.rs_val :
                         ex_mem.ctrl.jump     ? ex_mem.jump_target :
                                                ex_mem.br_target;

    assign mem_req.addr  = ex_mem.alu_result;
    assign mem_req.wdata = ex_mem.store_data;
    assign mem_req.we    = ex_mem.valid && ex_mem.ctrl.mem_we;

    always_comb begin
        case (ex_mem.ctrl.wb_sel)
            core_pkg::WB_MEM: wb_data = mem_rdata;
            core_pkg::WB_PC4: wb_data = ex_mem.pc_plus4;
            default:          wb_data = ex_mem.alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        retire.pc   <= ex_mem.pc;
        retire.we   <= ex_mem.ctrl.reg_we && (ex_mem.rd != '0);
        retire.rd   <= ex_mem.rd;
        retire.data <= wb_data;
        if (rst) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= ex_mem.valid;
        end
    end

    // a store reaching MEM right after a redirect would be on the wrong path
    a_store_valid: assert property (@(posedge clk) disable iff (rst)
        mem_req.we |-> !$past(redirect));

endmodule

// ==== hw/execute_stage.sv ====
`include "core_defs.svh"

module execute_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               redirect,
    input  core_pkg::id_ex_t   id_ex,
    output core_pkg::ex_mem_t  ex_mem
);
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] br_target;
    logic             zero;
    logic             negative;

    assign op_a = id_ex.ctrl.shamt_src ? {{(`XLEN-5){1'b0}}, id_ex.shamt} : id_ex.rs_val;
    assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rt_val;

    alu u_alu (
        .a        (op_a),
        .b        (op_b),
        .op       (id_ex.ctrl.alu_op),
        .result   (alu_result),
        .zero     (zero),
        .negative (negative)
    );

    // word offset relative to the next instruction
    assign br_target = id_ex.pc_plus4 + {id_ex.imm[`XLEN-3:0], 2'b00};

    always_ff @(posedge clk) begin
        ex_mem.ctrl        <= id_ex.ctrl;
        ex_mem.alu_result  <= alu_result;
        ex_mem.zero        <= zero;
        ex_mem.negative    <= negative;
        ex_mem.br_target   <= br_target;
        ex_mem.jump_target <= id_ex.jump_target;
        ex_mem.rs_val      <= id_ex.rs_val;
        ex_mem.store_data  <= id_ex.rt_val;
        ex_mem.pc_plus4    <= id_ex.pc_plus4;
        ex_mem.pc          <= id_ex.pc;
        ex_mem.rd          <= id_ex.rd;
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid && !redirect;
        end
    end

endmodule

// ==== hw/decode_stage.sv ====
`include "core_defs.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               redirect,
    input  core_pkg::if_id_t   if_id,
    output logic [4:0]         rs_num,
    output logic [4:0]         rt_num,
    input  logic [`XLEN-1:0]   rs_data,
    input  logic [`XLEN-1:0]   rt_data,
    output core_pkg::id_ex_t   id_ex
);
    core_pkg::ctrl_t   ctrl;
    logic              legal;
    logic [`XLEN-1:0]  imm;
    logic [4:0]        dest;
    logic              cmp_zero;

    inst_decoder u_inst_decoder (
        .inst  (if_id.inst),
        .ctrl  (ctrl),
        .legal (legal)
    );

    assign rs_num = if_id.inst[25:21];
    assign rt_num = if_id.inst[20:16];

    assign imm = ctrl.zero_ext ? {{(`XLEN-16){1'b0}}, if_id.inst[15:0]}
                               : {{(`XLEN-16){if_id.inst[15]}}, if_id.inst[15:0]};

    // blez, bgtz and bgez test rs alone, so the compare operand is forced to zero
    assign cmp_zero = ctrl.branch inside {core_pkg::BR_LEZ, core_pkg::BR_GTZ,
                                          core_pkg::BR_GEZ};

    always_comb begin
        if (!ctrl.reg_we) begin
            dest = '0;
        end else if (ctrl.wb_sel == core_pkg::WB_PC4) begin
            dest = 5'(`LINK_REG);
        end else if (if_id.inst[31:26] == core_pkg::OP_RTYPE) begin
            dest = if_id.inst[15:11];
        end else begin
            dest = if_id.inst[20:16];
        end
    end

    always_ff @(posedge clk) begin
        id_ex.ctrl        <= ctrl;
        id_ex.rs_val      <= rs_data;
        id_ex.rt_val      <= cmp_zero ? '0 : rt_data;
        id_ex.imm         <= imm;
        id_ex.shamt       <= if_id.inst[10:6];
        id_ex.jump_target <= {if_id.pc_plus4[`XLEN-1:28], if_id.inst[25:0], 2'b00};
        id_ex.pc_plus4    <= if_id.pc_plus4;
        id_ex.pc          <= if_id.pc;
        id_ex.rd          <= dest;
        if (rst) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= if_id.valid && legal && !redirect;
        end
    end

endmodule

// ==== hw/fetch_stage.sv ====
`include "core_defs.svh"

module fetch_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               redirect,
    input  logic [`XLEN-1:0]   redirect_pc,
    input  logic [`XLEN-1:0]   inst,
    output logic [`XLEN-1:0]   inst_addr,
    output core_pkg::if_id_t   if_id
);
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_plus4;

    assign pc_plus4  = pc + `XLEN'd4;
    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else begin
            pc <= redirect ? redirect_pc : pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if_id.pc       <= pc;
        if_id.pc_plus4 <= pc_plus4;
        if_id.inst     <= inst;
        // the word fetched alongside a taken redirect is on the wrong path
        if (rst) begin
            if_id.valid <= 1'b0;
        end else begin
            if_id.valid <= !redirect;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        inst_addr[1:0] == 2'b00);

endmodule

// ==== hw/alu.sv ====
`include "core_defs.svh"

module alu (
    input  logic [`XLEN-1:0]   a,
    input  logic [`XLEN-1:0]   b,
    input  core_pkg::alu_op_e  op,
    output logic [`XLEN-1:0]   result,
    output logic               zero,
    output logic               negative
);
    localparam int SHW = $clog2(`XLEN);

    logic [SHW-1:0] sh;

    // shift amount comes from a, either rs or the shamt field
    assign sh = a[SHW-1:0];

    always_comb begin
        case (op)
            core_pkg::ALU_ADD: result = a + b;
            core_pkg::ALU_SUB: result = a - b;
            core_pkg::ALU_AND: result = a & b;
            core_pkg::ALU_OR:  result = a | b;
            core_pkg::ALU_XOR: result = a ^ b;
            core_pkg::ALU_NOR: result = ~(a | b);
            core_pkg::ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            core_pkg::ALU_SLL: result = b << sh;
            core_pkg::ALU_SRL: result = b >> sh;
            core_pkg::ALU_SRA: result = $unsigned($signed(b) >>> sh);
            core_pkg::ALU_LUI: result = {b[`XLEN-17:0], 16'h0000};
            default:           result = '0;
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[`XLEN-1];

endmodule

// ==== hw/reg_file.sv ====
`include "core_defs.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          rs_num,
    input  logic [4:0]          rt_num,
    output logic [`XLEN-1:0]    rs_data,
    output logic [`XLEN-1:0]    rt_data,
    input  core_pkg::retire_t   retire
);
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];
    logic             wr_en;

    assign wr_en = retire.valid && retire.we && (retire.rd != '0);

    // a write in this cycle is visible to the read ports
    function automatic logic [`XLEN-1:0] read_port(input logic [4:0] num);
        if (num == '0) begin
            return '0;
        end
        if (wr_en && (retire.rd == num)) begin
            return retire.data;
        end
        return regs[num];
    endfunction

    always_comb begin
        rs_data = read_port(rs_num);
        rt_data = read_port(rt_num);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[retire.rd] <= retire.data;
        end
    end

    // writeback never targets register zero with the write enable up
    a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
        retire.valid && retire.we |-> retire.rd != '0);

endmodule

// ==== hw/inst_decoder.sv ====
`include "core_defs.svh"

module inst_decoder (
    input  logic [`XLEN-1:0] inst,
    output core_pkg::ctrl_t  ctrl,
    output logic             legal
);
    core_pkg::opcode_e opcode;
    core_pkg::funct_e  funct;

    assign opcode = core_pkg::opcode_e'(inst[31:26]);
    assign funct  = core_pkg::funct_e'(inst[5:0]);

    always_comb begin
        // cleared word means add, no write, no branch, writeback from ALU
        ctrl  = '0;
        legal = 1'b1;
        case (opcode)
            core_pkg::OP_RTYPE: begin
                ctrl.reg_we = 1'b1;
                case (funct)
                    core_pkg::FN_ADD, core_pkg::FN_ADDU: ctrl.alu_op = core_pkg::ALU_ADD;
                    core_pkg::FN_SUB, core_pkg::FN_SUBU: ctrl.alu_op = core_pkg::ALU_SUB;
                    core_pkg::FN_AND:  ctrl.alu_op = core_pkg::ALU_AND;
                    core_pkg::FN_OR:   ctrl.alu_op = core_pkg::ALU_OR;
                    core_pkg::FN_XOR:  ctrl.alu_op = core_pkg::ALU_XOR;
                    core_pkg::FN_NOR:  ctrl.alu_op = core_pkg::ALU_NOR;
                    core_pkg::FN_SLT:  ctrl.alu_op = core_pkg::ALU_SLT;
                    core_pkg::FN_SLLV: ctrl.alu_op = core_pkg::ALU_SLL;
                    core_pkg::FN_SRLV: ctrl.alu_op = core_pkg::ALU_SRL;
                    core_pkg::FN_SLL, core_pkg::FN_SRL, core_pkg::FN_SRA: begin
                        // fixed shifts take the amount from the shamt field
                        ctrl.shamt_src = 1'b1;
                        ctrl.alu_op = (funct == core_pkg::FN_SLL) ? core_pkg::ALU_SLL :
                                      (funct == core_pkg::FN_SRL) ? core_pkg::ALU_SRL :
                                                                    core_pkg::ALU_SRA;
                    end
                    core_pkg::FN_JR: begin
                        ctrl.reg_we   = 1'b0;
                        ctrl.jump_reg = 1'b1;
                    end
                    default: legal = 1'b0;
                endcase
            end
            core_pkg::OP_ADDI, core_pkg::OP_ADDIU, core_pkg::OP_SLTI,
            core_pkg::OP_ANDI, core_pkg::OP_ORI, core_pkg::OP_XORI, core_pkg::OP_LUI: begin
                ctrl.reg_we      = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.zero_ext    = opcode inside {core_pkg::OP_ANDI, core_pkg::OP_ORI,
                                                  core_pkg::OP_XORI};
                case (opcode)
                    core_pkg::OP_SLTI: ctrl.alu_op = core_pkg::ALU_SLT;
                    core_pkg::OP_ANDI: ctrl.alu_op = core_pkg::ALU_AND;
                    core_pkg::OP_ORI:  ctrl.alu_op = core_pkg::ALU_OR;
                    core_pkg::OP_XORI: ctrl.alu_op = core_pkg::ALU_XOR;
                    core_pkg::OP_LUI:  ctrl.alu_op = core_pkg::ALU_LUI;
                    default:           ctrl.alu_op = core_pkg::ALU_ADD;
                endcase
            end
            core_pkg::OP_LW: begin
                ctrl.reg_we      = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.wb_sel      = core_pkg::WB_MEM;
            end
            core_pkg::OP_SW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_we      = 1'b1;
            end
            // branches compare through a subtract, flags are read in MEM
            core_pkg::OP_BEQ:  ctrl.branch = core_pkg::BR_EQ;
            core_pkg::OP_BNE:  ctrl.branch = core_pkg::BR_NE;
            core_pkg::OP_BLEZ: ctrl.branch = core_pkg::BR_LEZ;
            core_pkg::OP_BGTZ: ctrl.branch = core_pkg::BR_GTZ;
            core_pkg::OP_REGIMM: begin
                ctrl.branch = core_pkg::BR_GEZ;
                legal       = (inst[20:16] == 5'd1);
            end
            core_pkg::OP_J: ctrl.jump = 1'b1;
            core_pkg::OP_JAL: begin
                ctrl.jump   = 1'b1;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = core_pkg::WB_PC4;
            end
            default: legal = 1'b0;
        endcase
        if (ctrl.branch != core_pkg::BR_NONE) begin
            ctrl.alu_op = core_pkg::ALU_SUB;
        end
    end

endmodule

// ==== hw/core_pkg.sv ====
`include "core_defs.svh"

package core_pkg;

    // primary opcodes, REGIMM only carries BGEZ here
    typedef enum logic [5:0] {
        OP_RTYPE  = 6'h00,
        OP_REGIMM = 6'h01,
        OP_J      = 6'h02,
        OP_JAL    = 6'h03,
        OP_BEQ    = 6'h04,
        OP_BNE    = 6'h05,
        OP_BLEZ   = 6'h06,
        OP_BGTZ   = 6'h07,
        OP_ADDI   = 6'h08,
        OP_ADDIU  = 6'h09,
        OP_SLTI   = 6'h0a,
        OP_ANDI   = 6'h0c,
        OP_ORI    = 6'h0d,
        OP_XORI   = 6'h0e,
        OP_LUI    = 6'h0f,
        OP_LW     = 6'h23,
        OP_SW     = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_JR   = 6'h08,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a
    } funct_e;

    // add is zero so a cleared control word is a plain add
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_GEZ
    } branch_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_PC4
    } wb_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    shamt_src;
        logic    zero_ext;
        logic    reg_we;
        wb_sel_e wb_sel;
        logic    mem_we;
        branch_e branch;
        logic    jump;
        logic    jump_reg;
    } ctrl_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  pc_plus4;
        logic [`XLEN-1:0]  inst;
    } if_id_t;

    typedef struct packed {
        logic              valid;
        ctrl_t             ctrl;
        logic [`XLEN-1:0]  rs_val;
        logic [`XLEN-1:0]  rt_val;
        logic [`XLEN-1:0]  imm;
        logic [4:0]        shamt;
        logic [`XLEN-1:0]  jump_target;
        logic [`XLEN-1:0]  pc_plus4;
        logic [`XLEN-1:0]  pc;
        logic [4:0]        rd;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        ctrl_t             ctrl;
        logic [`XLEN-1:0]  alu_result;
        logic              zero;
        logic              negative;
        logic [`XLEN-1:0]  br_target;
        logic [`XLEN-1:0]  jump_target;
        logic [`XLEN-1:0]  rs_val;
        logic [`XLEN-1:0]  store_data;
        logic [`XLEN-1:0]  pc_plus4;
        logic [`XLEN-1:0]  pc;
        logic [4:0]        rd;
    } ex_mem_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic              we;
        logic [4:0]        rd;
        logic [`XLEN-1:0]  data;
    } retire_t;

    typedef struct packed {
        logic [`XLEN-1:0]  addr;
        logic [`XLEN-1:0]  wdata;
        logic              we;
    } mem_req_t;

endpackage

// ==== hw/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and address width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// integer register count, register zero included
`define NUM_REGS 32

// JAL writes its return address here
`define LINK_REG 31

`endif
